// ==== com_rx/com_rx.sv ====
`timescale 1ns/10ps
`include "com_params.svh"

module com_rx (
    input  logic                   clk,
    input  logic                   rst,
    input  com_pkg::com_word_u     line_in,
    input  logic                   line_in_valid,
    output logic                   ram_we,
    output logic [`COM_RAM_AW-1:0] ram_waddr,
    output logic [`COM_DW-1:0]     ram_wdata,
    output logic                   fs_rx,
    input  logic                   fd_rx,
    output com_pkg::btype_e        rx_btype
);

    localparam logic [`COM_RAM_AW-1:0] RX_BASE = `COM_RX_BASE;
    localparam logic [`COM_LW-1:0] LEN_ONE = 1;

    typedef enum logic [1:0] {R_HDR, R_DATA, R_SUM, R_HOLD} rstate_e;

    rstate_e                state;
    logic [`COM_LW-1:0]     left;
    logic [`COM_DW-1:0]     sum;
    logic [`COM_RAM_AW-1:0] waddr;
    com_pkg::btype_e        hdr_btype;

    assign ram_we    = (state == R_DATA) && line_in_valid;
    assign ram_waddr = waddr;
    assign ram_wdata = line_in.data;
    // line is ignored while the report is pending.
    assign fs_rx     = (state == R_HOLD);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= R_HDR;
            left      <= '0;
            sum       <= '0;
            waddr     <= RX_BASE;
            hdr_btype <= com_pkg::INIT;
            rx_btype  <= com_pkg::INIT;
        end else begin
            case (state)
                R_HDR: begin
                    if (line_in_valid) begin
                        hdr_btype <= line_in.hdr.btype;
                        left      <= line_in.hdr.dlen;
                        sum       <= '0;
                        waddr     <= RX_BASE;
                        state     <= (line_in.hdr.dlen == '0) ? R_SUM : R_DATA;
                    end
                end
                R_DATA: begin
                    if (line_in_valid) begin
                        sum   <= sum + line_in.data;
                        waddr <= waddr + 1'b1;
                        left  <= left - 1'b1;
                        if (left == LEN_ONE) state <= R_SUM;
                    end
                end
                R_SUM: begin
                    if (line_in_valid) begin
                        rx_btype <= (line_in.data == sum) ? hdr_btype : com_pkg::ERROR;
                        state    <= R_HOLD;
                    end
                end
                default: if (fd_rx) state <= R_HDR;
            endcase
        end
    end

endmodule

// ==== com_tx/com_tx.sv ====
`timescale 1ns/10ps
`include "com_params.svh"

module com_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fs_tx,
    output logic                   fd_tx,
    input  com_pkg::tx_job_t       tx_job,
    output logic [`COM_RAM_AW-1:0] ram_raddr,
    input  logic [`COM_DW-1:0]     ram_rdata,
    output com_pkg::com_word_u     line_out,
    output logic                   line_out_valid
);

    // body covers the header and data words on the line.
    typedef enum logic [1:0] {T_IDLE, T_BODY, T_SUM, T_DONE} tstate_e;

    tstate_e                state;
    logic [`COM_RAM_AW-1:0] addr;
    logic [`COM_LW-1:0]     left;
    logic [`COM_DW-1:0]     sum;
    com_pkg::com_hdr_t      hdr;

    assign hdr = '{btype: tx_job.btype, dlen: tx_job.ram_rlen};

    // first word is fetched while still idle.
    assign ram_raddr      = (state == T_IDLE) ? tx_job.ram_init[`COM_RAM_AW-1:0] : addr;
    assign line_out_valid = (state == T_BODY) || (state == T_SUM);
    assign fd_tx          = (state == T_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= T_IDLE;
            addr  <= '0;
            left  <= '0;
            sum   <= '0;
        end else begin
            case (state)
                T_IDLE: begin
                    if (fs_tx) begin
                        state <= T_BODY;
                        addr  <= tx_job.ram_init[`COM_RAM_AW-1:0] + 1'b1;
                        left  <= tx_job.ram_rlen;
                        sum   <= '0;
                    end
                end
                T_BODY: begin
                    if (left == '0) begin
                        state <= T_SUM;
                    end else begin
                        addr <= addr + 1'b1;
                        left <= left - 1'b1;
                        sum  <= sum + ram_rdata;
                    end
                end
                T_SUM:   state <= T_DONE;
                default: state <= T_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == T_IDLE) begin
            line_out.hdr <= hdr;
        end else if (state == T_BODY) begin
            line_out.data <= (left == '0) ? sum : ram_rdata;
        end
    end

endmodule

// ==== common/com_params.svh ====
`ifndef COM_PARAMS_SVH
`define COM_PARAMS_SVH

// line and buffer word width.
`define COM_DW 16

// length and address field width.
`define COM_LW 12

// buffer address bits, higher address bits are ignored.
`define COM_RAM_AW 9

// received data lands here in the buffer.
`define COM_RX_BASE 256

// cycles to wait for an answer or for host pickup.
`define COM_TIMEOUT 128
`define COM_NUMOUT 16

`endif

// ==== common/com_pkg.sv ====
`include "com_params.svh"

package com_pkg;

    // packet type codes as carried in the header.
    typedef enum logic [3:0] {
        INIT   = 4'b0000,
        ACK    = 4'b0001,
        NAK    = 4'b0010,
        STL    = 4'b0011,
        DIDX   = 4'b0101,
        DPARAM = 4'b0110,
        DDIDX  = 4'b0111,
        DLINK  = 4'b1000,
        DTYPE  = 4'b1001,
        DTEMP  = 4'b1010,
        DATA0  = 4'b1101,
        DATA1  = 4'b1110,
        ERROR  = 4'b1111
    } btype_e;

    typedef struct packed {
        btype_e             btype;
        logic [`COM_LW-1:0] dlen;
    } com_hdr_t;

    // first word of a frame is a header, the rest are data.
    typedef union packed {
        com_hdr_t           hdr;
        logic [`COM_DW-1:0] data;
    } com_word_u;

    typedef struct packed {
        btype_e             btype;
        logic [`COM_LW-1:0] ram_init;
        logic [`COM_LW-1:0] ram_rlen;
    } tx_job_t;

endpackage

// ==== hdl/com_cs.sv ====
`timescale 1ns/10ps
`include "com_params.svh"

module com_cs (
    input  logic               clk,
    input  logic               rst,

    input  logic               fs_send,
    output logic               fd_send,
    output logic               fd_txer,
    output logic               fs_read,
    input  logic               fd_read,
    output com_pkg::btype_e    read_btype,

    input  com_pkg::btype_e    send_btype,
    input  logic [`COM_LW-1:0] send_dlen,
    input  logic [`COM_LW-1:0] ram_addr_init,

    output logic               fs_tx,
    input  logic               fd_tx,
    output com_pkg::tx_job_t   tx_job,

    input  logic               fs_rx,
    output logic               fd_rx,
    input  com_pkg::btype_e    rx_btype
);

    localparam int TW = $clog2(`COM_TIMEOUT + 1);
    localparam int NW = $clog2(`COM_NUMOUT + 1);
    localparam logic [TW-1:0] TIME_LAST = `COM_TIMEOUT - 1;
    localparam logic [NW-1:0] NUM_LAST = `COM_NUMOUT - 1;

    typedef enum logic [3:0] {
        MAIN_IDLE,
        MAIN_WAIT,
        SEND_PREP,
        SEND_DATA,
        SEND_DONE,
        SEND_EROR,
        RANS_WAIT,
        RANS_TAKE,
        RANS_DONE,
        READ_PREP,
        READ_DATA,
        WANS_PREP,
        WANS_DONE,
        READ_DONE
    } state_e;

    state_e          state;
    state_e          next_state;
    state_e          state_goto;
    logic [TW-1:0]   time_cnt;
    logic [NW-1:0]   num_cnt;
    logic            time_up;
    logic            last_try;
    com_pkg::btype_e ans_btype;

    assign time_up  = (time_cnt >= TIME_LAST);
    assign last_try = (num_cnt >= NUM_LAST);

    assign fd_send = (state == SEND_DONE);
    assign fd_txer = (state == SEND_EROR);
    assign fs_read = (state == READ_DONE);
    assign fs_tx   = (state == SEND_DATA) || (state == WANS_DONE);
    assign fd_rx   = (state == RANS_DONE) || (state == READ_DATA);

    // --------------------
    // state sequencing.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= MAIN_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            MAIN_IDLE: next_state = MAIN_WAIT;
            MAIN_WAIT: begin
                if (fs_send) next_state = SEND_PREP;
                else if (fs_rx) next_state = READ_PREP;
            end
            SEND_PREP: next_state = SEND_DATA;
            SEND_DATA: if (fd_tx) next_state = RANS_WAIT;
            RANS_WAIT: begin
                if (fs_rx) next_state = RANS_TAKE;
                else if (time_up) next_state = SEND_EROR;
            end
            RANS_TAKE: next_state = RANS_DONE;
            // NAK goes straight back to sending.
            RANS_DONE: if (!fs_rx) next_state = state_goto;
            SEND_DONE: if (!fs_send) next_state = MAIN_WAIT;
            SEND_EROR: if (!fs_send) next_state = MAIN_WAIT;
            READ_PREP: next_state = READ_DATA;
            READ_DATA: if (!fs_rx) next_state = WANS_PREP;
            WANS_PREP: next_state = WANS_DONE;
            WANS_DONE: if (fd_tx) next_state = READ_DONE;
            READ_DONE: if (fd_read || time_up) next_state = MAIN_WAIT;
            default: next_state = MAIN_IDLE;
        endcase
    end

    // outcome of the answer just taken.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_goto <= MAIN_IDLE;
        end else if (state == RANS_TAKE) begin
            if (rx_btype == com_pkg::ACK) state_goto <= SEND_DONE;
            else if (rx_btype == com_pkg::NAK && last_try) state_goto <= SEND_EROR;
            else if (rx_btype == com_pkg::NAK) state_goto <= SEND_DATA;
            else state_goto <= SEND_DONE;
        end
    end

    // --------------------
    // answer to a received frame.
    always_comb begin
        if (last_try) ans_btype = com_pkg::ACK;
        else if (rx_btype == com_pkg::ERROR) ans_btype = com_pkg::NAK;
        else ans_btype = com_pkg::ACK;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            read_btype <= com_pkg::INIT;
        end else if (state == MAIN_WAIT) begin
            read_btype <= com_pkg::INIT;
        end else if (state == WANS_PREP) begin
            read_btype <= rx_btype;
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEND_PREP) begin
            tx_job <= '{btype: send_btype, ram_init: ram_addr_init, ram_rlen: send_dlen};
        end else if (state == WANS_PREP) begin
            tx_job <= '{btype: ans_btype, ram_init: '0, ram_rlen: '0};
        end
    end

    // --------------------
    // timeout and transmission counters.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= '0;
        end else if (state == RANS_WAIT || state == READ_DONE) begin
            time_cnt <= time_cnt + 1'b1;
        end else begin
            time_cnt <= '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num_cnt <= '0;
        end else if (state == SEND_PREP || state == SEND_DONE || state == SEND_EROR) begin
            num_cnt <= '0;
        end else if (state == RANS_TAKE) begin
            num_cnt <= num_cnt + 1'b1;
        end else if (state == WANS_PREP) begin
            // peer retries are counted until a frame is taken.
            num_cnt <= (ans_btype == com_pkg::NAK) ? num_cnt + 1'b1 : '0;
        end
    end

endmodule

// ==== hdl/com_link.sv ====
`timescale 1ns/10ps
`include "com_params.svh"

module com_link (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fs_send,
    output logic                   fd_send,
    output logic                   fd_txer,
    output logic                   fs_read,
    input  logic                   fd_read,
    output com_pkg::btype_e        read_btype,
    input  com_pkg::btype_e        send_btype,
    input  logic [`COM_LW-1:0]     send_dlen,
    input  logic [`COM_LW-1:0]     ram_addr_init,
    input  logic                   host_we,
    input  logic [`COM_RAM_AW-1:0] host_addr,
    input  logic [`COM_DW-1:0]     host_wdata,
    output logic [`COM_DW-1:0]     host_rdata,
    output com_pkg::com_word_u     line_out,
    output logic                   line_out_valid,
    input  com_pkg::com_word_u     line_in,
    input  logic                   line_in_valid
);

    logic                   fs_tx;
    logic                   fd_tx;
    logic                   fs_rx;
    logic                   fd_rx;
    com_pkg::tx_job_t       tx_job;
    com_pkg::btype_e        rx_btype;
    logic [`COM_RAM_AW-1:0] tx_raddr;
    logic                   rx_we;
    logic [`COM_RAM_AW-1:0] rx_waddr;
    logic [`COM_DW-1:0]     rx_wdata;
    logic [`COM_RAM_AW-1:0] link_addr;
    logic [`COM_DW-1:0]     link_rdata;

    // --------------------
    // framer owns the link port only while sending.
    assign link_addr = fs_tx ? tx_raddr : rx_waddr;

    com_cs u_cs (
        .clk           (clk),
        .rst           (rst),
        .fs_send       (fs_send),
        .fd_send       (fd_send),
        .fd_txer       (fd_txer),
        .fs_read       (fs_read),
        .fd_read       (fd_read),
        .read_btype    (read_btype),
        .send_btype    (send_btype),
        .send_dlen     (send_dlen),
        .ram_addr_init (ram_addr_init),
        .fs_tx         (fs_tx),
        .fd_tx         (fd_tx),
        .tx_job        (tx_job),
        .fs_rx         (fs_rx),
        .fd_rx         (fd_rx),
        .rx_btype      (rx_btype)
    );

    com_tx u_tx (
        .clk            (clk),
        .rst            (rst),
        .fs_tx          (fs_tx),
        .fd_tx          (fd_tx),
        .tx_job         (tx_job),
        .ram_raddr      (tx_raddr),
        .ram_rdata      (link_rdata),
        .line_out       (line_out),
        .line_out_valid (line_out_valid)
    );

    com_rx u_rx (
        .clk           (clk),
        .rst           (rst),
        .line_in       (line_in),
        .line_in_valid (line_in_valid),
        .ram_we        (rx_we),
        .ram_waddr     (rx_waddr),
        .ram_wdata     (rx_wdata),
        .fs_rx         (fs_rx),
        .fd_rx         (fd_rx),
        .rx_btype      (rx_btype)
    );

    com_ram u_ram (
        .clk        (clk),
        .host_we    (host_we),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rdata (host_rdata),
        .link_we    (rx_we),
        .link_addr  (link_addr),
        .link_wdata (rx_wdata),
        .link_rdata (link_rdata)
    );

endmodule

// ==== hdl/com_ram.sv ====
`timescale 1ns/10ps
`include "com_params.svh"

module com_ram (
    input  logic                   clk,
    input  logic                   host_we,
    input  logic [`COM_RAM_AW-1:0] host_addr,
    input  logic [`COM_DW-1:0]     host_wdata,
    output logic [`COM_DW-1:0]     host_rdata,
    input  logic                   link_we,
    input  logic [`COM_RAM_AW-1:0] link_addr,
    input  logic [`COM_DW-1:0]     link_wdata,
    output logic [`COM_DW-1:0]     link_rdata
);

    logic [`COM_DW-1:0] mem [0:(1 << `COM_RAM_AW)-1];

    // host write wins on the same address.
    always_ff @(posedge clk) begin
        if (link_we) mem[link_addr] <= link_wdata;
        if (host_we) mem[host_addr] <= host_wdata;
    end

    always_ff @(posedge clk) begin
        host_rdata <= mem[host_addr];
        link_rdata <= mem[link_addr];
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module com_link_tb \
    -o com_link_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/com_link_sim > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -qx "TEST RESULT: PASS" sim.log && exit 0 || exit 1

// ==== src.f ====
+incdir+common
common/com_pkg.sv
hdl/com_ram.sv
com_tx/com_tx.sv
com_rx/com_rx.sv
hdl/com_cs.sv
hdl/com_link.sv
tests/com_link_properties.sv
tests/com_link_tb.sv

// ==== tests/com_link_properties.sv ====
`timescale 1ns/10ps

module com_link_properties (
    input logic clk,
    input logic rst,
    input logic fd_send,
    input logic fd_txer,
    input logic fs_tx,
    input logic fd_tx,
    input logic fs_rx,
    input logic fd_rx
);

    // the two send results exclude each other.
    done_exclusive: assert property (
        @(posedge clk) disable iff (rst) !(fd_send && fd_txer)
    ) else $error("fd_send and fd_txer are high together");

    rx_done_order: assert property (
        @(posedge clk) disable iff (rst) $rose(fd_rx) |-> fs_rx
    ) else $error("fd_rx rose while fs_rx was low");

    // framer request falls right after its done.
    tx_req_drop: assert property (
        @(posedge clk) disable iff (rst) fd_tx |=> !fs_tx
    ) else $error("fs_tx still high one cycle after fd_tx");

endmodule

bind com_cs com_link_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .fd_send (fd_send),
    .fd_txer (fd_txer),
    .fs_tx   (fs_tx),
    .fd_tx   (fd_tx),
    .fs_rx   (fs_rx),
    .fd_rx   (fd_rx)
);

// ==== tests/com_link_tb.sv ====
`timescale 1ns/10ps
`include "com_params.svh"

module com_link_tb;

    localparam int NSTEP = 7;

    // one row of the step table.
    typedef struct packed {
        logic               peer;
        com_pkg::btype_e    btype;
        logic [`COM_LW-1:0] dlen;
        logic [4:0]         naks;
        logic               ack;
        logic               corrupt;
        logic               exp_ok;
        logic [4:0]         exp_frames;
        com_pkg::btype_e    exp_ans;
        com_pkg::btype_e    exp_read;
    } step_t;

    logic                   clk;
    logic                   rst;
    logic                   fs_send;
    logic                   fd_send;
    logic                   fd_txer;
    logic                   fs_read;
    logic                   fd_read;
    com_pkg::btype_e        read_btype;
    com_pkg::btype_e        send_btype;
    logic [`COM_LW-1:0]     send_dlen;
    logic [`COM_LW-1:0]     ram_addr_init;
    logic                   host_we;
    logic [`COM_RAM_AW-1:0] host_addr;
    logic [`COM_DW-1:0]     host_wdata;
    logic [`COM_DW-1:0]     host_rdata;
    com_pkg::com_word_u     line_out;
    logic                   line_out_valid;
    com_pkg::com_word_u     line_in;
    logic                   line_in_valid;

    step_t              steps [0:NSTEP-1];
    integer             seed;
    logic [`COM_DW-1:0] data_buf [0:63];
    com_pkg::com_word_u frame_words [$];
    int                 frame_cnt;
    logic               valid_seen;

    com_link uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            stop_with_error($sformatf("[FAIL] %0t ns %s: got %0h, expected %0h",
                                      $time, name, got, exp));
        end
    endtask

    // --------------------
    // line peer.
    // counts frame starts on line_out.
    always @(negedge clk) begin
        if (line_out_valid && !valid_seen) frame_cnt++;
        valid_seen = line_out_valid;
    end

    task automatic capture_frame(input int nwords);
        int cnt;
        int k;
        cnt = 0;
        frame_words.delete();
        while (!line_out_valid) begin
            next_cycle();
            cnt++;
            if (cnt > `COM_TIMEOUT) stop_with_error("timeout: no frame appeared on line_out");
        end
        for (k = 0; k < nwords; k++) begin
            assert (line_out_valid) else stop_with_error("line_out_valid dropped inside a frame");
            frame_words.push_back(line_out);
            next_cycle();
        end
        assert (!line_out_valid) else stop_with_error("frame on line_out is too long");
    endtask

    task automatic check_frame(input com_pkg::btype_e btype, input logic [`COM_LW-1:0] dlen,
                               input logic [`COM_DW-1:0] sum);
        int k;
        check_value("line_out.hdr.btype", frame_words[0].hdr.btype, btype);
        check_value("line_out.hdr.dlen", frame_words[0].hdr.dlen, dlen);
        for (k = 0; k < dlen; k++) begin
            check_value("line_out.data", frame_words[k + 1].data, data_buf[k]);
        end
        check_value("line_out checksum", frame_words[dlen + 1].data, sum);
    endtask

    task automatic send_frame(input com_pkg::btype_e btype, input logic [`COM_LW-1:0] dlen,
                              input logic [`COM_DW-1:0] chk);
        int k;
        line_in.hdr = '{btype: btype, dlen: dlen};
        line_in_valid = 1'b1;
        next_cycle();
        for (k = 0; k < dlen; k++) begin
            line_in.data = data_buf[k];
            next_cycle();
        end
        line_in.data = chk;
        next_cycle();
        line_in_valid = 1'b0;
    endtask

    // --------------------
    task automatic host_send_step(input step_t s, input logic [`COM_LW-1:0] init);
        logic [`COM_DW-1:0] sum;
        logic               stop;
        int                 frames;
        int                 cnt;
        int                 k;
        sum = '0;
        frame_cnt = 0;
        for (k = 0; k < s.dlen; k++) begin
            data_buf[k] = 16'($random(seed));
            sum = sum + data_buf[k];
            host_we = 1'b1;
            host_addr = 9'(init + k);
            host_wdata = data_buf[k];
            next_cycle();
        end
        host_we = 1'b0;
        send_btype = s.btype;
        send_dlen = s.dlen;
        ram_addr_init = init;
        fs_send = 1'b1;
        frames = 0;
        stop = 1'b0;
        while (!stop) begin
            capture_frame(s.dlen + 2);
            frames++;
            check_frame(s.btype, s.dlen, sum);
            if (frames <= s.naks) begin
                send_frame(com_pkg::NAK, '0, '0);
                stop = (frames == `COM_NUMOUT);
            end else begin
                if (s.ack) send_frame(com_pkg::ACK, '0, '0);
                stop = 1'b1;
            end
        end
        cnt = 0;
        while (!(fd_send || fd_txer)) begin
            assert (!line_out_valid) else stop_with_error("unexpected extra frame on line_out");
            next_cycle();
            cnt++;
            if (cnt > `COM_TIMEOUT + 20) stop_with_error("timeout: send never finished");
        end
        check_value("frame count", frame_cnt, s.exp_frames);
        check_value("fd_send", fd_send, s.exp_ok);
        check_value("fd_txer", fd_txer, !s.exp_ok);
        fs_send = 1'b0;
        cnt = 0;
        while (fd_send || fd_txer) begin
            next_cycle();
            cnt++;
            if (cnt > 10) stop_with_error("timeout: done signal stayed high after fs_send fell");
        end
    endtask

    task automatic peer_send_step(input step_t s);
        logic [`COM_DW-1:0] sum;
        int                 cnt;
        int                 k;
        sum = '0;
        for (k = 0; k < s.dlen; k++) begin
            data_buf[k] = 16'($random(seed));
            sum = sum + data_buf[k];
        end
        send_frame(s.btype, s.dlen, s.corrupt ? sum + 1'b1 : sum);
        capture_frame(2);
        check_frame(s.exp_ans, '0, '0);
        cnt = 0;
        while (!fs_read) begin
            next_cycle();
            cnt++;
            if (cnt > 20) stop_with_error("timeout: fs_read did not rise");
        end
        check_value("read_btype", read_btype, s.exp_read);
        if (!s.corrupt) begin
            for (k = 0; k < s.dlen; k++) begin
                host_addr = 9'(`COM_RX_BASE + k);
                next_cycle();
                check_value("host_rdata", host_rdata, data_buf[k]);
            end
        end
        fd_read = 1'b1;
        cnt = 0;
        while (fs_read) begin
            next_cycle();
            cnt++;
            if (cnt > 10) stop_with_error("timeout: fs_read stayed high after fd_read");
        end
        fd_read = 1'b0;
        next_cycle();
    endtask

    initial begin : watchdog
        longint limit;
        int     i;
        wait (rst === 1'b0);
        limit = 10;
        for (i = 0; i < NSTEP; i++) begin
            limit += `COM_NUMOUT * (steps[i].dlen + 3 + `COM_TIMEOUT) + 200;
        end
        repeat (limit) @(posedge clk);
        stop_with_error("timeout: watchdog limit reached before the table finished");
    end

    initial begin : main
        int i;
        seed = 32'h3be74a2c;
        rst = 1'b1;
        fs_send = 1'b0;
        fd_read = 1'b0;
        send_btype = com_pkg::INIT;
        send_dlen = '0;
        ram_addr_init = '0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        line_in = '0;
        line_in_valid = 1'b0;
        // peer, btype, dlen, naks, ack, corrupt, ok, frames, answer, read type.
        steps[0] = '{1'b0, com_pkg::DATA0, 12'd5, 5'd0, 1'b1, 1'b0,
                     1'b1, 5'd1, com_pkg::ACK, com_pkg::INIT};
        steps[1] = '{1'b0, com_pkg::STL, 12'd0, 5'd0, 1'b1, 1'b0,
                     1'b1, 5'd1, com_pkg::ACK, com_pkg::INIT};
        steps[2] = '{1'b0, com_pkg::DATA1, 12'd3, 5'd2, 1'b1, 1'b0,
                     1'b1, 5'd3, com_pkg::ACK, com_pkg::INIT};
        steps[3] = '{1'b0, com_pkg::DIDX, 12'd4, 5'd0, 1'b0, 1'b0,
                     1'b0, 5'd1, com_pkg::ACK, com_pkg::INIT};
        steps[4] = '{1'b0, com_pkg::DPARAM, 12'd2, 5'(`COM_NUMOUT), 1'b0, 1'b0,
                     1'b0, 5'(`COM_NUMOUT), com_pkg::ACK, com_pkg::INIT};
        steps[5] = '{1'b1, com_pkg::DTYPE, 12'd6, 5'd0, 1'b0, 1'b0,
                     1'b0, 5'd1, com_pkg::ACK, com_pkg::DTYPE};
        steps[6] = '{1'b1, com_pkg::DATA0, 12'd4, 5'd0, 1'b0, 1'b1,
                     1'b0, 5'd1, com_pkg::NAK, com_pkg::ERROR};
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        for (i = 0; i < NSTEP; i++) begin
            if (steps[i].peer) peer_send_step(steps[i]);
            else host_send_step(steps[i], 12'(8 + 40 * i));
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
